/* Bender.yml */
package:
  name: arcade_io

sources:
  - include_dirs:
      - .
    files:
      - ctrl_pkg.sv
      - av_pkg.sv
      - key_decoder.sv
      - control_mapper.sv
      - reset_sequencer.sv
      - reset_timer.sv
      - audio_dac.sv
      - arcade_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_checker.sv
      - tb_arcade_io.sv

/* arcade_consts.svh */
// Scan codes, joystick bit positions, reset hold length and data widths
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ==================================================
// Keyboard scan codes (set 2)
// ==================================================
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_COIN    8'h76 // Esc
`define KEY_START1  8'h05 // F1
`define KEY_START2  8'h06 // F2
`define KEY_FIRE2   8'h11 // Alt
`define KEY_FIRE1   8'h29 // Space

// Joystick bit positions, fire2 sits at bit 5
`define JOY_RIGHT   0
`define JOY_LEFT    1
`define JOY_DOWN    2
`define JOY_UP      3
`define JOY_FIRE1   4

// ==================================================
// Reset stretch and widths
// ==================================================
`define RESET_HOLD_CYCLES 16
`define RESET_CNT_W       5
`define SCAN_CODE_W       8
`define JOY_W             8
`define SAMPLE_W          8
`define MIX_W             11
`define MIX_MAX           1275 // 255 + 4 * 255

`endif

/* arcade_io_top.sv */
// Control and audio top level: key decoder, mapper, reset FSM, hold timer, DAC
module arcade_io_top (
	input  logic                   clk_24,
	input  logic                   reset,
	input  ctrl_pkg::key_event_t   key_event,
	input  ctrl_pkg::joy_t         joy_0,
	input  ctrl_pkg::joy_t         joy_1,
	input  ctrl_pkg::cfg_t         cfg,
	input  logic                   user_reset,
	input  av_pkg::audio_pair_t    audio,
	output ctrl_pkg::player_ctl_t  p1,
	output ctrl_pkg::player_ctl_t  p2,
	output logic                   game_reset,
	output logic                   audio_bit
);

	ctrl_pkg::key_btn_t btns;
	logic reset_any;
	logic timer_start;
	logic timer_done;

	// Any source holds the game in reset
	assign reset_any = cfg.reset_req | cfg.reset_trig | user_reset;

	// ==================================================
	// Controls
	// ==================================================
	key_decoder key_decoder_inst (
		.clk_24    (clk_24),
		.reset     (reset),
		.key_event (key_event),
		.btns      (btns)
	);

	control_mapper control_mapper_inst (
		.clk_24 (clk_24),
		.reset  (reset),
		.btns   (btns),
		.joy_0  (joy_0),
		.joy_1  (joy_1),
		.rotate (cfg.rotate),
		.p1     (p1),
		.p2     (p2)
	);

	// ==================================================
	// Game reset
	// ==================================================
	reset_sequencer reset_sequencer_inst (
		.clk_24      (clk_24),
		.reset       (reset),
		.reset_req   (reset_any),
		.timer_done  (timer_done),
		.timer_start (timer_start),
		.game_reset  (game_reset)
	);

	reset_timer reset_timer_inst (
		.clk_24 (clk_24),
		.reset  (reset),
		.start  (timer_start),
		.done   (timer_done)
	);

	audio_dac audio_dac_inst (
		.clk_24    (clk_24),
		.reset     (reset),
		.audio     (audio),
		.audio_bit (audio_bit)
	);

endmodule

/* audio_dac.sv */
// Two-channel audio mixer with a first-order delta-sigma output
`include "arcade_consts.svh"

module audio_dac (
	input  logic                 clk_24,
	input  logic                 reset,
	input  av_pkg::audio_pair_t  audio,
	output logic                 audio_bit
);

	av_pkg::mix_t mix;
	av_pkg::mix_t acc;
	logic [`MIX_W:0] sum; // Carry in the top bit

	// Mix a + 4*b
	always_ff @(posedge clk_24) begin
		mix <= av_pkg::mix_t'(audio.a) + {audio.b, 2'b00};
	end

	assign sum = {1'b0, acc} + {1'b0, mix};

	// ==================================================
	// Accumulator with the carry out as the bit stream
	// ==================================================
	always_ff @(posedge clk_24) begin
		if (reset) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[`MIX_W-1:0];
			audio_bit <= sum[`MIX_W];
		end
	end

	// Output bit high exactly when the accumulator wrapped
	a_carry_wrap: assert property (
		@(posedge clk_24) disable iff (reset)
		audio_bit == (acc < $past(acc))
	);

endmodule

/* av_pkg.sv */
// Audio types: channel sample, mixed value, channel pair
`include "arcade_consts.svh"

package av_pkg;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	// Wide enough for a + 4*b
	typedef logic [`MIX_W-1:0] mix_t;

	typedef struct packed {
		sample_t a;
		sample_t b; // Weighted by four in the mix
	} audio_pair_t;

endpackage

/* control_mapper.sv */
// Merges keyboard and joysticks into the two registered player control vectors
`include "arcade_consts.svh"

module control_mapper (
	input  logic                   clk_24,
	input  logic                   reset,
	input  ctrl_pkg::key_btn_t     btns,
	input  ctrl_pkg::joy_t         joy_0,
	input  ctrl_pkg::joy_t         joy_1,
	input  logic                   rotate,
	output ctrl_pkg::player_ctl_t  p1,
	output ctrl_pkg::player_ctl_t  p2
);

	logic up_any, down_any, left_any, right_any;
	logic m_up, m_down, m_left, m_right;
	logic fire;

	// Keyboard plus both sticks
	assign up_any    = btns.up    | joy_0[`JOY_UP]    | joy_1[`JOY_UP];
	assign down_any  = btns.down  | joy_0[`JOY_DOWN]  | joy_1[`JOY_DOWN];
	assign left_any  = btns.left  | joy_0[`JOY_LEFT]  | joy_1[`JOY_LEFT];
	assign right_any = btns.right | joy_0[`JOY_RIGHT] | joy_1[`JOY_RIGHT];
	assign fire      = btns.fire1 | joy_0[`JOY_FIRE1] | joy_1[`JOY_FIRE1];

	// Rotated cabinet when rotate is low
	assign m_up    = rotate ? up_any    : right_any;
	assign m_down  = rotate ? down_any  : left_any;
	assign m_left  = rotate ? left_any  : up_any;
	assign m_right = rotate ? right_any : down_any;

	always_ff @(posedge clk_24) begin
		if (reset) begin
			p1 <= '0;
			p2 <= '0;
		end else begin
			p1.coin  <= btns.coin;
			p1.start <= btns.start1;
			p1.jump  <= fire;
			p1.up    <= 1'b0;
			p1.down  <= 1'b0;
			p1.left  <= m_left;
			p1.right <= m_right;

			p2.coin  <= 1'b0; // Coin slot is shared on p1
			p2.start <= btns.start2;
			p2.jump  <= fire;
			p2.up    <= 1'b0;
			p2.down  <= 1'b0;
			p2.left  <= m_up;
			p2.right <= m_down;
		end
	end

endmodule

/* ctrl_pkg.sv */
// Control types: key event, buttons, joystick, player vector, config, reset FSM state
`include "arcade_consts.svh"

package ctrl_pkg;

	typedef logic [`SCAN_CODE_W-1:0] scan_code_t;
	typedef logic [`JOY_W-1:0]       joy_t;      // right, left, down, up, fire1, fire2 from bit 0
	typedef logic [`RESET_CNT_W-1:0] hold_cnt_t;

	// Keyboard event word, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		scan_code_t code;
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
	} key_btn_t;

	// Same field order as the game's CSJUDLR port
	typedef struct packed {
		logic coin;
		logic start;
		logic jump;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_ctl_t;

	typedef struct packed {
		logic rotate;     // 1 = controls not rotated
		logic reset_req;
		logic reset_trig;
	} cfg_t;

	typedef enum logic [1:0] {
		RST_ASSERT,
		RST_HOLD,
		RST_RUN
	} reset_state_t;

endpackage

/* key_decoder.sv */
// Keyboard event decoder that latches the pressed state of each known key
`include "arcade_consts.svh"

module key_decoder (
	input  logic                  clk_24,
	input  logic                  reset,
	input  ctrl_pkg::key_event_t  key_event,
	output ctrl_pkg::key_btn_t    btns
);

	logic prev_toggle;
	logic toggle_chg;

	assign toggle_chg = key_event.toggle != prev_toggle;

	// Last toggle seen on the event word
	always_ff @(posedge clk_24) begin
		prev_toggle <= key_event.toggle;
	end

	always_ff @(posedge clk_24) begin
		if (reset) begin
			btns <= '0;
		end else if (toggle_chg) begin
			case (key_event.code)
				`KEY_UP:     btns.up     <= key_event.pressed;
				`KEY_DOWN:   btns.down   <= key_event.pressed;
				`KEY_LEFT:   btns.left   <= key_event.pressed;
				`KEY_RIGHT:  btns.right  <= key_event.pressed;
				`KEY_COIN:   btns.coin   <= key_event.pressed;
				`KEY_START1: btns.start1 <= key_event.pressed;
				`KEY_START2: btns.start2 <= key_event.pressed;
				`KEY_FIRE1:  btns.fire1  <= key_event.pressed;
				`KEY_FIRE2:  btns.fire2  <= key_event.pressed;
				default: begin
					// Unknown code leaves the buttons alone
				end
			endcase
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Buttons only move on the edge after a toggle change
	a_btns_need_event: assert property (
		@(posedge clk_24) disable iff (reset)
		!toggle_chg |=> $stable(btns)
	);

endmodule

/* reset_sequencer.sv */
// Reset FSM that stretches game_reset past the end of the reset request
module reset_sequencer (
	input  logic clk_24,
	input  logic reset,
	input  logic reset_req,
	input  logic timer_done,
	output logic timer_start,
	output logic game_reset
);

	ctrl_pkg::reset_state_t state;

	always_ff @(posedge clk_24) begin
		if (reset) begin
			state       <= ctrl_pkg::RST_ASSERT;
			timer_start <= 1'b0;
		end else begin
			// One-cycle kick when the request is seen low
			timer_start <= (state == ctrl_pkg::RST_ASSERT) && !reset_req;

			case (state)
				ctrl_pkg::RST_ASSERT: begin
					if (!reset_req)
						state <= ctrl_pkg::RST_HOLD;
				end
				ctrl_pkg::RST_HOLD: begin
					if (reset_req)
						state <= ctrl_pkg::RST_ASSERT; // Restart the stretch
					else if (timer_done)
						state <= ctrl_pkg::RST_RUN;
				end
				ctrl_pkg::RST_RUN: begin
					if (reset_req)
						state <= ctrl_pkg::RST_ASSERT;
				end
				default: state <= ctrl_pkg::RST_ASSERT;
			endcase
		end
	end

	assign game_reset = (state != ctrl_pkg::RST_RUN);

	// ==================================================
	// Checks
	// ==================================================
	// Game leaves reset only when the hold timer ends with no request
	a_run_after_hold: assert property (
		@(posedge clk_24) disable iff (reset)
		$fell(game_reset) |-> $past(timer_done) && !$past(reset_req)
	);

endmodule

/* reset_timer.sv */
// Down-counter timing the reset hold, pulses done in its last cycle
`include "arcade_consts.svh"

module reset_timer (
	input  logic clk_24,
	input  logic reset,
	input  logic start,
	output logic done
);

	ctrl_pkg::hold_cnt_t cnt;
	logic busy;

	always_ff @(posedge clk_24) begin
		if (reset) begin
			cnt  <= '0;
			busy <= 1'b0;
		end else if (start) begin
			cnt  <= `RESET_CNT_W'(`RESET_HOLD_CYCLES);
			busy <= 1'b1;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == `RESET_CNT_W'(1))
				busy <= 1'b0; // Last cycle of the hold
		end
	end

	// A reload cancels the pending pulse
	assign done = (cnt == `RESET_CNT_W'(1)) && !start;

	// Counter and busy flag must agree
	a_no_done_idle: assert property (
		@(posedge clk_24) disable iff (reset)
		!busy |-> !done
	);

endmodule

/* sim.f */
+incdir+.
ctrl_pkg.sv
av_pkg.sv
key_decoder.sv
control_mapper.sv
reset_sequencer.sv
reset_timer.sv
audio_dac.sv
arcade_io_top.sv
tb_clock.sv
tb_checker.sv
tb_arcade_io.sv

/* tb_arcade_io.sv */
// Testbench top: clock, DUT, checker, stimulus table with expected values, watchdog
`include "arcade_consts.svh"

module tb_arcade_io;

	localparam logic [1:0] CHK_NONE    = 2'd0;
	localparam logic [1:0] CHK_PLAYER  = 2'd1;
	localparam logic [1:0] CHK_RESET   = 2'd2;
	localparam logic [1:0] CHK_DENSITY = 2'd3;

	// One table row, inputs then expected outputs
	typedef struct packed {
		logic [1:0]            kind;
		logic [11:0]           wait_cyc;
		ctrl_pkg::key_event_t  key_event;
		ctrl_pkg::joy_t        joy_0;
		ctrl_pkg::joy_t        joy_1;
		ctrl_pkg::cfg_t        cfg;
		logic                  user_reset;
		av_pkg::audio_pair_t   audio;
		ctrl_pkg::player_ctl_t p1;
		ctrl_pkg::player_ctl_t p2;
		logic                  game_reset;
		logic [11:0]           bits;
	} row_t;

	logic clk_24;
	logic reset;
	ctrl_pkg::key_event_t key_event;
	ctrl_pkg::joy_t joy_0;
	ctrl_pkg::joy_t joy_1;
	ctrl_pkg::cfg_t cfg;
	logic user_reset;
	av_pkg::audio_pair_t audio;
	ctrl_pkg::player_ctl_t p1;
	ctrl_pkg::player_ctl_t p2;
	logic game_reset;
	logic audio_bit;

	logic chk_valid;
	logic [1:0] chk_kind;
	int chk_id;
	ctrl_pkg::player_ctl_t exp_p1;
	ctrl_pkg::player_ctl_t exp_p2;
	logic exp_reset;
	logic [11:0] exp_bits;
	int test_cnt;
	int fail_cnt;

	row_t table_q[$];
	row_t cur;                      // Input state while the table is built
	ctrl_pkg::key_btn_t btn_model;  // Keyboard buttons as the events leave them
	logic [31:0] rng;
	int n_checks;
	int limit_cycles;
	logic table_ready = 1'b0;

	tb_clock #(.PERIOD(20)) tb_clock_inst (.clk_24(clk_24));

	arcade_io_top arcade_io_top_inst (
		.clk_24     (clk_24),
		.reset      (reset),
		.key_event  (key_event),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.cfg        (cfg),
		.user_reset (user_reset),
		.audio      (audio),
		.p1         (p1),
		.p2         (p2),
		.game_reset (game_reset),
		.audio_bit  (audio_bit)
	);

	tb_checker tb_checker_inst (
		.clk_24     (clk_24),
		.p1         (p1),
		.p2         (p2),
		.game_reset (game_reset),
		.audio_bit  (audio_bit),
		.chk_valid  (chk_valid),
		.chk_kind   (chk_kind),
		.chk_id     (chk_id),
		.exp_p1     (exp_p1),
		.exp_p2     (exp_p2),
		.exp_reset  (exp_reset),
		.exp_bits   (exp_bits),
		.test_cnt   (test_cnt),
		.fail_cnt   (fail_cnt)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Appends the current inputs with the outputs they should give
	task automatic push_row(input logic [1:0] kind, input int cycles, input logic rst_exp);
		row_t r;
		logic [3:0] dir; // up, down, left, right
		logic fire;
		r = cur;
		dir = {btn_model.up, btn_model.down, btn_model.left, btn_model.right}
			| r.joy_0[3:0] | r.joy_1[3:0];
		if (!r.cfg.rotate)
			dir = {dir[0], dir[1], dir[3], dir[2]}; // Cabinet turned a quarter
		fire = btn_model.fire1 | r.joy_0[4] | r.joy_1[4];
		r.p1 = {btn_model.coin, btn_model.start1, fire, 2'b00, dir[1], dir[0]};
		r.p2 = {1'b0, btn_model.start2, fire, 2'b00, dir[3], dir[2]};
		r.bits = 12'(r.audio.a) + 12'(r.audio.b) * 12'd4;
		r.kind = kind;
		r.wait_cyc = 12'(cycles);
		r.game_reset = rst_exp;
		if (kind != CHK_NONE)
			n_checks++;
		table_q.push_back(r);
	endtask

	// Key event, flip says whether the toggle bit changes
	task automatic key(input logic [7:0] code, input logic pressed, input logic flip);
		cur.key_event = {cur.key_event.toggle ^ flip, pressed, 1'b0, code};
		if (flip) begin
			case (code)
				`KEY_UP:     btn_model.up = pressed;
				`KEY_DOWN:   btn_model.down = pressed;
				`KEY_LEFT:   btn_model.left = pressed;
				`KEY_RIGHT:  btn_model.right = pressed;
				`KEY_COIN:   btn_model.coin = pressed;
				`KEY_START1: btn_model.start1 = pressed;
				`KEY_START2: btn_model.start2 = pressed;
				`KEY_FIRE1:  btn_model.fire1 = pressed;
				`KEY_FIRE2:  btn_model.fire2 = pressed;
				default: ;
			endcase
		end
		push_row(CHK_PLAYER, 2, 1'b0);
	endtask

	// All requests drop; reset stays high for the hold, then falls
	task automatic release_req();
		cur.cfg.reset_req = 1'b0;
		cur.cfg.reset_trig = 1'b0;
		cur.user_reset = 1'b0;
		push_row(CHK_RESET, `RESET_HOLD_CYCLES + 1, 1'b1);
		push_row(CHK_RESET, 1, 1'b0);
	endtask

	task automatic build_table();
		cur = '0;
		btn_model = '0;
		rng = 32'h6e05;
		n_checks = 0;
		release_req(); // Leaving reset counts as a dropped request
		push_row(CHK_PLAYER, 1, 1'b0);
		key(`KEY_START1, 1'b1, 1'b1);
		key(`KEY_START1, 1'b0, 1'b1);
		key(`KEY_COIN, 1'b1, 1'b1);
		key(`KEY_START2, 1'b1, 1'b1);
		key(`KEY_LEFT, 1'b1, 1'b1);
		key(`KEY_LEFT, 1'b0, 1'b0);   // Same toggle, ignored
		key(8'h1C, 1'b1, 1'b1);       // Unknown code
		key(`KEY_FIRE1, 1'b1, 1'b1);
		key(`KEY_COIN, 1'b0, 1'b1);
		key(`KEY_START2, 1'b0, 1'b1);
		key(`KEY_LEFT, 1'b0, 1'b1);
		key(`KEY_FIRE1, 1'b0, 1'b1);
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			cur.joy_0 = rng[7:0];
			cur.joy_1 = rng[15:8];
			cur.cfg.rotate = i[0];
			push_row(CHK_PLAYER, 1, 1'b0);
		end
		cur.joy_0 = '0;
		cur.joy_1 = '0;

		// ==================================================
		// Reset sources, then a request during the hold
		// ==================================================
		cur.cfg.reset_req = 1'b1;
		push_row(CHK_RESET, 3, 1'b1);
		release_req();
		cur.cfg.reset_trig = 1'b1;
		push_row(CHK_RESET, 3, 1'b1);
		release_req();
		cur.user_reset = 1'b1;
		push_row(CHK_RESET, 3, 1'b1);
		release_req();
		cur.user_reset = 1'b1;
		push_row(CHK_RESET, 2, 1'b1);
		cur.user_reset = 1'b0;
		push_row(CHK_RESET, 8, 1'b1);
		cur.cfg.reset_req = 1'b1;
		push_row(CHK_RESET, 1, 1'b1);
		release_req();

		for (int i = 0; i < 4; i++) begin
			rng = xorshift32(rng);
			cur.audio = (i == 3) ? 16'hFFFF : rng[15:0]; // Last one is full scale
			push_row(CHK_NONE, 2, 1'b0);                  // Mix settles
			push_row(CHK_DENSITY, 2048, 1'b0);
		end
	endtask

	task automatic apply(input row_t r);
		key_event = r.key_event;
		joy_0 = r.joy_0;
		joy_1 = r.joy_1;
		cfg = r.cfg;
		user_reset = r.user_reset;
		audio = r.audio;
	endtask

	initial begin
		reset = 1'b1;
		key_event = '0;
		joy_0 = '0;
		joy_1 = '0;
		cfg = '0;
		user_reset = 1'b0;
		audio = '0;
		chk_valid = 1'b0;
		chk_kind = CHK_NONE;
		chk_id = 0;
		exp_p1 = '0;
		exp_p2 = '0;
		exp_reset = 1'b0;
		exp_bits = '0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(negedge clk_24);
		reset = 1'b0;
		apply(table_q[0]);
		for (int i = 0; i < table_q.size(); i++) begin
			repeat (table_q[i].wait_cyc) begin
				@(negedge clk_24);
				chk_valid = 1'b0;
			end
			chk_valid = 1'b1; // Checked on the next rising edge
			chk_kind = table_q[i].kind;
			chk_id = i;
			exp_p1 = table_q[i].p1;
			exp_p2 = table_q[i].p2;
			exp_reset = table_q[i].game_reset;
			exp_bits = table_q[i].bits;
			if (i + 1 < table_q.size())
				apply(table_q[i + 1]);
		end
		@(negedge clk_24);
		chk_valid = 1'b0;
		@(negedge clk_24);
		$display("Checks run: %0d of %0d, failed: %0d", test_cnt, n_checks, fail_cnt);
		if (fail_cnt == 0 && test_cnt == n_checks) begin
			$display("TEST OK");
		end else begin
			if (test_cnt != n_checks)
				$display("Checker ran fewer or more checks than the table holds");
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (table_ready === 1'b1);
		limit_cycles = 8 + 4096;
		foreach (table_q[i])
			limit_cycles += table_q[i].wait_cyc;
		repeat (limit_cycles) @(posedge clk_24);
		$display("Watchdog expired after %0d cycles, the table did not complete", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb_checker.sv */
// Output checker: compares DUT outputs with expected values, counts checks and failures
module tb_checker (
	input  logic                  clk_24,
	input  ctrl_pkg::player_ctl_t p1,
	input  ctrl_pkg::player_ctl_t p2,
	input  logic                  game_reset,
	input  logic                  audio_bit,
	input  logic                  chk_valid,
	input  logic [1:0]            chk_kind,
	input  int                    chk_id,
	input  ctrl_pkg::player_ctl_t exp_p1,
	input  ctrl_pkg::player_ctl_t exp_p2,
	input  logic                  exp_reset,
	input  logic [11:0]           exp_bits,
	output int                    test_cnt,
	output int                    fail_cnt
);

	localparam logic [1:0] CHK_NONE    = 2'd0;
	localparam logic [1:0] CHK_PLAYER  = 2'd1;
	localparam logic [1:0] CHK_RESET   = 2'd2;
	localparam logic [1:0] CHK_DENSITY = 2'd3;

	logic [11:0] bit_cnt; // audio_bit highs in the current window
	int fails;

	function automatic string kind_name(input logic [1:0] k);
		case (k)
			CHK_PLAYER: return "player vectors";
			CHK_RESET:  return "game reset";
			default:    return "audio density";
		endcase
	endfunction

	initial begin
		test_cnt = 0;
		fail_cnt = 0;
	end

	// Registered outputs are read before this edge updates them
	always @(posedge clk_24) begin
		if (chk_valid && chk_kind != CHK_NONE) begin
			fails = 0;
			if (chk_kind == CHK_PLAYER && p1 !== exp_p1) begin
				$display("MISMATCH at %0t: p1 is %b, expected %b", $time, p1, exp_p1);
				fails++;
			end
			if (chk_kind == CHK_PLAYER && p2 !== exp_p2) begin
				$display("MISMATCH at %0t: p2 is %b, expected %b", $time, p2, exp_p2);
				fails++;
			end
			if (chk_kind == CHK_RESET && game_reset !== exp_reset) begin
				$display("MISMATCH at %0t: game_reset is %b, expected %b",
					$time, game_reset, exp_reset);
				fails++;
			end
			if (chk_kind == CHK_DENSITY && bit_cnt !== exp_bits) begin
				$display("MISMATCH at %0t: audio_bit count is %0d, expected %0d",
					$time, bit_cnt, exp_bits);
				fails++;
			end
			test_cnt++;
			if (fails != 0)
				fail_cnt++;
			$display("check %0d (%s): %s", chk_id, kind_name(chk_kind), fails ? "bad" : "good");
		end

		// ==================================================
		// Density window, restarted by every check
		// ==================================================
		if (chk_valid)
			bit_cnt <= {11'd0, audio_bit};
		else
			bit_cnt <= bit_cnt + audio_bit;
	end

endmodule

/* tb_clock.sv */
// Testbench clock generator
module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk_24
);

	initial begin
		clk_24 = 1'b0;
		forever #(PERIOD / 2) clk_24 = ~clk_24;
	end

endmodule
